/* Makefile */
.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory"

test:
	verilator --binary --timing -Wno-fatal -f tb.f --top-module cluster_bus_tb -Mdir obj_dir
	@out="$$(./obj_dir/Vcluster_bus_tb)"; echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

/* hw/cluster_addr_decoder.sv */
// cluster address decoder building the rule table from the cluster id
module cluster_addr_decoder #(
  // tcdm must be non-zero and fit below the peripheral window (at most 2 MiB)
  parameter int unsigned TCDM_SIZE = 256 * 1024,
  parameter logic [cluster_bus_cfg_pkg::ADDR_WIDTH-1:0] BASE_ADDR   = 32'h5000_0000,
  parameter logic [cluster_bus_cfg_pkg::ADDR_WIDTH-1:0] PERIPH_OFFS = 32'h0020_0000,
  parameter logic [cluster_bus_cfg_pkg::ADDR_WIDTH-1:0] EXT_OFFS    = 32'h0040_0000
) (
  input  logic [5:0]                                 cluster_id_i,
  input  logic [cluster_bus_cfg_pkg::ADDR_WIDTH-1:0] addr_i,
  output cluster_bus_cfg_pkg::tgt_sel_t              tgt_o
);

  localparam int unsigned AW = cluster_bus_cfg_pkg::ADDR_WIDTH;

  logic [AW-1:0]                   cluster_base;
  cluster_bus_cfg_pkg::addr_rule_t rules [cluster_bus_cfg_pkg::N_RULES];
  logic                            hit_found;

  // each cluster owns a 4 MiB slot above the base address
  assign cluster_base = BASE_ADDR + (AW'(cluster_id_i) << 22);

  assign rules[0] = '{idx:        cluster_bus_cfg_pkg::TGT_TCDM,
                      start_addr: cluster_base,
                      end_addr:   cluster_base + AW'(TCDM_SIZE)};
  assign rules[1] = '{idx:        cluster_bus_cfg_pkg::TGT_PERIPH,
                      start_addr: cluster_base + PERIPH_OFFS,
                      end_addr:   cluster_base + EXT_OFFS};
  // everything above the cluster
  assign rules[2] = '{idx:        cluster_bus_cfg_pkg::TGT_EXT,
                      start_addr: cluster_base + EXT_OFFS,
                      end_addr:   {AW{1'b1}}};
  // everything below the cluster
  assign rules[3] = '{idx:        cluster_bus_cfg_pkg::TGT_EXT,
                      start_addr: '0,
                      end_addr:   cluster_base};

  // first matching rule wins, the top address falls through to external
  always_comb begin
    tgt_o     = cluster_bus_cfg_pkg::TGT_EXT;
    hit_found = 1'b0;
    for (int r = 0; r < cluster_bus_cfg_pkg::N_RULES; r++) begin
      if (!hit_found && addr_i >= rules[r].start_addr && addr_i < rules[r].end_addr) begin
        tgt_o     = rules[r].idx;
        hit_found = 1'b1;
      end
    end
  end

endmodule

/* hw/cluster_bus_arbiter.sv */
// per-target round-robin arbiter with grant lock and request id extension
module cluster_bus_arbiter (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  input  cluster_bus_chan_pkg::init_req_t         req_i [cluster_bus_cfg_pkg::NB_INIT],
  input  logic [cluster_bus_cfg_pkg::NB_INIT-1:0] req_valid_i,
  output logic [cluster_bus_cfg_pkg::NB_INIT-1:0] grant_ready_o,
  output cluster_bus_chan_pkg::tgt_req_t          tgt_req_o,
  input  logic                                    tgt_ready_i
);

  localparam int unsigned NI = cluster_bus_cfg_pkg::NB_INIT;
  localparam int unsigned IW = $clog2(NI);

  logic [IW-1:0] rr_ptr_q;
  logic          lock_q;
  logic [IW-1:0] lock_idx_q;
  logic [IW-1:0] rr_idx;
  logic          rr_found;
  logic [IW-1:0] cand;
  logic [IW-1:0] gnt_idx;
  logic          gnt_valid;

  // first valid request at or after the pointer
  always_comb begin
    rr_idx   = rr_ptr_q;
    rr_found = 1'b0;
    cand     = rr_ptr_q;
    for (int k = 0; k < NI; k++) begin
      cand = IW'((int'(rr_ptr_q) + k) % NI);
      if (!rr_found && req_valid_i[cand]) begin
        rr_idx   = cand;
        rr_found = 1'b1;
      end
    end
  end

  // locked grant keeps the payload stable under back-pressure
  assign gnt_idx   = lock_q ? lock_idx_q : rr_idx;
  assign gnt_valid = lock_q | rr_found;

  always_comb begin
    tgt_req_o.valid = gnt_valid;
    tgt_req_o.we    = req_i[gnt_idx].we;
    tgt_req_o.addr  = req_i[gnt_idx].addr;
    tgt_req_o.wdata = req_i[gnt_idx].wdata;
    // winner index on top, so the response can find its way back
    tgt_req_o.id    = {gnt_idx, req_i[gnt_idx].id};
    for (int i = 0; i < NI; i++) begin
      grant_ready_o[i] = gnt_valid && tgt_ready_i && (gnt_idx == IW'(i));
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_ptr_q   <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (gnt_valid && tgt_ready_i) begin
      rr_ptr_q <= IW'((int'(gnt_idx) + 1) % NI);
      lock_q   <= 1'b0;
    end else if (gnt_valid) begin
      lock_q     <= 1'b1;
      lock_idx_q <= gnt_idx;
    end
  end

endmodule

/* hw/cluster_bus_cfg_pkg.sv */
// bus widths, port counts, target indices and the address-map rule type
package cluster_bus_cfg_pkg;

  // bus geometry
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;

  // initiators: core data, icache refill, dma, external bus
  localparam int unsigned NB_INIT = 4;

  // targets: tcdm, cluster peripherals, external bus
  localparam int unsigned NB_TARGET = 3;

  // id grows by the initiator index on the way to a target
  localparam int unsigned ID_IN_WIDTH  = 4;
  localparam int unsigned ID_OUT_WIDTH = ID_IN_WIDTH + $clog2(NB_INIT);

  typedef logic [1:0] tgt_sel_t;

  localparam tgt_sel_t TGT_TCDM   = 2'd0;
  localparam tgt_sel_t TGT_PERIPH = 2'd1;
  localparam tgt_sel_t TGT_EXT    = 2'd2;

  // tcdm, peripherals, above cluster, below cluster
  localparam int unsigned N_RULES = 4;

  // one address window, end address is exclusive
  typedef struct packed {
    tgt_sel_t                idx;
    logic [ADDR_WIDTH-1:0]   start_addr;
    logic [ADDR_WIDTH-1:0]   end_addr;
  } addr_rule_t;

endpackage

/* hw/cluster_bus_chan_pkg.sv */
// request and response channel structs for initiator and target ports
package cluster_bus_chan_pkg;

  // request beat as issued by an initiator
  typedef struct packed {
    logic                                      valid;
    logic                                      we;
    logic [cluster_bus_cfg_pkg::ADDR_WIDTH-1:0]   addr;
    logic [cluster_bus_cfg_pkg::DATA_WIDTH-1:0]   wdata;
    logic [cluster_bus_cfg_pkg::ID_IN_WIDTH-1:0]  id;
  } init_req_t;

  // request beat at a target, id carries the initiator index on top
  typedef struct packed {
    logic                                      valid;
    logic                                      we;
    logic [cluster_bus_cfg_pkg::ADDR_WIDTH-1:0]   addr;
    logic [cluster_bus_cfg_pkg::DATA_WIDTH-1:0]   wdata;
    logic [cluster_bus_cfg_pkg::ID_OUT_WIDTH-1:0] id;
  } tgt_req_t;

  // response beat delivered to an initiator
  typedef struct packed {
    logic                                      valid;
    logic [cluster_bus_cfg_pkg::DATA_WIDTH-1:0]   rdata;
    logic [cluster_bus_cfg_pkg::ID_IN_WIDTH-1:0]  id;
  } init_rsp_t;

  // response beat from a target, still with the prefixed id
  typedef struct packed {
    logic                                      valid;
    logic [cluster_bus_cfg_pkg::DATA_WIDTH-1:0]   rdata;
    logic [cluster_bus_cfg_pkg::ID_OUT_WIDTH-1:0] id;
  } tgt_rsp_t;

endpackage

/* hw/cluster_bus_demux.sv */
// per-initiator request steering toward the decoded target and ready return
module cluster_bus_demux #(
  parameter int unsigned TCDM_SIZE = 256 * 1024,
  parameter logic [cluster_bus_cfg_pkg::ADDR_WIDTH-1:0] BASE_ADDR   = 32'h5000_0000,
  parameter logic [cluster_bus_cfg_pkg::ADDR_WIDTH-1:0] PERIPH_OFFS = 32'h0020_0000,
  parameter logic [cluster_bus_cfg_pkg::ADDR_WIDTH-1:0] EXT_OFFS    = 32'h0040_0000
) (
  input  logic                                       clk_i,
  input  logic                                       rst_n_i,
  input  logic [5:0]                                 cluster_id_i,
  input  cluster_bus_chan_pkg::init_req_t            req_i,
  output logic                                       req_ready_o,
  output logic [cluster_bus_cfg_pkg::NB_TARGET-1:0]  tgt_valid_o,
  input  logic [cluster_bus_cfg_pkg::NB_TARGET-1:0]  tgt_ready_i
);

  cluster_bus_cfg_pkg::tgt_sel_t dec_tgt;
  cluster_bus_cfg_pkg::tgt_sel_t sel;
  cluster_bus_cfg_pkg::tgt_sel_t sel_q;
  logic                          stall_q;

  cluster_addr_decoder #(
    .TCDM_SIZE   (TCDM_SIZE),
    .BASE_ADDR   (BASE_ADDR),
    .PERIPH_OFFS (PERIPH_OFFS),
    .EXT_OFFS    (EXT_OFFS)
  ) u_decoder (
    .cluster_id_i (cluster_id_i),
    .addr_i       (req_i.addr),
    .tgt_o        (dec_tgt)
  );

  // a stalled request keeps the target it was first steered to
  assign sel = stall_q ? sel_q : dec_tgt;

  always_comb begin
    for (int t = 0; t < cluster_bus_cfg_pkg::NB_TARGET; t++) begin
      tgt_valid_o[t] = req_i.valid && (sel == cluster_bus_cfg_pkg::tgt_sel_t'(t));
    end
  end

  assign req_ready_o = req_i.valid && tgt_ready_i[sel];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      stall_q <= 1'b0;
      sel_q   <= cluster_bus_cfg_pkg::TGT_TCDM;
    end else if (req_i.valid && !req_ready_o) begin
      stall_q <= 1'b1;
      sel_q   <= sel;
    end else begin
      stall_q <= 1'b0;
    end
  end

endmodule

/* hw/cluster_bus_rsp_router.sv */
// response router returning target responses to initiators by id prefix
module cluster_bus_rsp_router (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  input  cluster_bus_chan_pkg::tgt_rsp_t            tgt_rsp_i [cluster_bus_cfg_pkg::NB_TARGET],
  output logic [cluster_bus_cfg_pkg::NB_TARGET-1:0] tgt_rsp_ready_o,
  output cluster_bus_chan_pkg::init_rsp_t           init_rsp_o [cluster_bus_cfg_pkg::NB_INIT],
  input  logic [cluster_bus_cfg_pkg::NB_INIT-1:0]   init_rsp_ready_i
);

  localparam int unsigned NI  = cluster_bus_cfg_pkg::NB_INIT;
  localparam int unsigned NT  = cluster_bus_cfg_pkg::NB_TARGET;
  localparam int unsigned IDI = cluster_bus_cfg_pkg::ID_IN_WIDTH;
  localparam int unsigned IDO = cluster_bus_cfg_pkg::ID_OUT_WIDTH;
  localparam int unsigned IW  = IDO - IDI;

  cluster_bus_cfg_pkg::tgt_sel_t pick  [NI];
  cluster_bus_cfg_pkg::tgt_sel_t sel_q [NI];
  logic [NI-1:0]                 pick_valid;
  logic [NI-1:0]                 hold_q;

  always_comb begin
    tgt_rsp_ready_o = '0;
    for (int i = 0; i < NI; i++) begin
      pick[i]       = sel_q[i];
      pick_valid[i] = hold_q[i];
      // downward scan, so the lowest target index wins
      if (!hold_q[i]) begin
        for (int t = NT - 1; t >= 0; t--) begin
          if (tgt_rsp_i[t].valid && tgt_rsp_i[t].id[IDO-1 -: IW] == IW'(i)) begin
            pick[i]       = cluster_bus_cfg_pkg::tgt_sel_t'(t);
            pick_valid[i] = 1'b1;
          end
        end
      end
      init_rsp_o[i].valid = pick_valid[i];
      init_rsp_o[i].rdata = tgt_rsp_i[pick[i]].rdata;
      init_rsp_o[i].id    = tgt_rsp_i[pick[i]].id[IDI-1:0];
      if (pick_valid[i] && init_rsp_ready_i[i]) begin
        tgt_rsp_ready_o[pick[i]] = 1'b1;
      end
    end
  end

  // keep the chosen target while the initiator stalls
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NI; i++) begin
      if (!rst_n_i) begin
        hold_q[i] <= 1'b0;
        sel_q[i]  <= cluster_bus_cfg_pkg::TGT_TCDM;
      end else begin
        hold_q[i] <= pick_valid[i] && !init_rsp_ready_i[i];
        sel_q[i]  <= pick[i];
      end
    end
  end

endmodule

/* hw/cluster_bus_xbar.sv */
// cluster crossbar top connecting request demuxes, arbiters and response router
module cluster_bus_xbar #(
  parameter int unsigned TCDM_SIZE = 256 * 1024,
  parameter logic [cluster_bus_cfg_pkg::ADDR_WIDTH-1:0] BASE_ADDR   = 32'h5000_0000,
  parameter logic [cluster_bus_cfg_pkg::ADDR_WIDTH-1:0] PERIPH_OFFS = 32'h0020_0000,
  parameter logic [cluster_bus_cfg_pkg::ADDR_WIDTH-1:0] EXT_OFFS    = 32'h0040_0000
) (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  input  logic [5:0]                                cluster_id_i,
  input  cluster_bus_chan_pkg::init_req_t           init_req_i [cluster_bus_cfg_pkg::NB_INIT],
  output logic [cluster_bus_cfg_pkg::NB_INIT-1:0]   init_req_ready_o,
  output cluster_bus_chan_pkg::init_rsp_t           init_rsp_o [cluster_bus_cfg_pkg::NB_INIT],
  input  logic [cluster_bus_cfg_pkg::NB_INIT-1:0]   init_rsp_ready_i,
  output cluster_bus_chan_pkg::tgt_req_t            tgt_req_o [cluster_bus_cfg_pkg::NB_TARGET],
  input  logic [cluster_bus_cfg_pkg::NB_TARGET-1:0] tgt_req_ready_i,
  input  cluster_bus_chan_pkg::tgt_rsp_t            tgt_rsp_i [cluster_bus_cfg_pkg::NB_TARGET],
  output logic [cluster_bus_cfg_pkg::NB_TARGET-1:0] tgt_rsp_ready_o
);

  localparam int unsigned NI = cluster_bus_cfg_pkg::NB_INIT;
  localparam int unsigned NT = cluster_bus_cfg_pkg::NB_TARGET;

  // demux side is indexed by initiator, arbiter side by target
  logic [NT-1:0] dmx_valid [NI];
  logic [NT-1:0] dmx_ready [NI];
  logic [NI-1:0] arb_valid [NT];
  logic [NI-1:0] arb_ready [NT];

  for (genvar i = 0; i < NI; i++) begin : g_init
    cluster_bus_demux #(
      .TCDM_SIZE   (TCDM_SIZE),
      .BASE_ADDR   (BASE_ADDR),
      .PERIPH_OFFS (PERIPH_OFFS),
      .EXT_OFFS    (EXT_OFFS)
    ) u_demux (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .cluster_id_i (cluster_id_i),
      .req_i        (init_req_i[i]),
      .req_ready_o  (init_req_ready_o[i]),
      .tgt_valid_o  (dmx_valid[i]),
      .tgt_ready_i  (dmx_ready[i])
    );
    for (genvar t = 0; t < NT; t++) begin : g_cross
      assign arb_valid[t][i] = dmx_valid[i][t];
      assign dmx_ready[i][t] = arb_ready[t][i];
    end
  end

  for (genvar t = 0; t < NT; t++) begin : g_tgt
    cluster_bus_arbiter u_arbiter (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .req_i         (init_req_i),
      .req_valid_i   (arb_valid[t]),
      .grant_ready_o (arb_ready[t]),
      .tgt_req_o     (tgt_req_o[t]),
      .tgt_ready_i   (tgt_req_ready_i[t])
    );
  end

  cluster_bus_rsp_router u_rsp_router (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .tgt_rsp_i        (tgt_rsp_i),
    .tgt_rsp_ready_o  (tgt_rsp_ready_o),
    .init_rsp_o       (init_rsp_o),
    .init_rsp_ready_i (init_rsp_ready_i)
  );

endmodule

/* tb.f */
hw/cluster_bus_cfg_pkg.sv
hw/cluster_bus_chan_pkg.sv
hw/cluster_addr_decoder.sv
hw/cluster_bus_demux.sv
hw/cluster_bus_arbiter.sv
hw/cluster_bus_rsp_router.sv
hw/cluster_bus_xbar.sv
verification/cluster_bus_target_model.sv
verification/cluster_bus_tb.sv

/* verification/cluster_bus_target_model.sv */
// responding memory model with random request ready for one target port
module cluster_bus_target_model #(
  parameter logic [31:0] RD_KEY = 32'h0
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           stall_i,
  input  cluster_bus_chan_pkg::tgt_req_t req_i,
  output logic                           req_ready_o,
  output cluster_bus_chan_pkg::tgt_rsp_t rsp_o,
  input  logic                           rsp_ready_i
);

  integer seed;
  logic   rnd_q;

  initial begin
    seed  = 32'h9794_555f;
    rnd_q = 1'b0;
  end

  // new random ready each falling edge
  always @(negedge clk_i) begin
    rnd_q <= $random(seed) & 1;
  end

  // one request in flight at a time, held off by the stall input
  assign req_ready_o = rnd_q && !stall_i && !rsp_o.valid;

  // response one cycle after the accepted request
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_o <= '0;
    end else if (req_i.valid && req_ready_o) begin
      rsp_o.valid <= 1'b1;
      rsp_o.rdata <= req_i.addr ^ RD_KEY;
      rsp_o.id    <= req_i.id;
    end else if (rsp_ready_i) begin
      rsp_o.valid <= 1'b0;
    end
  end

endmodule

/* verification/cluster_bus_tb.sv */
// testbench for the cluster crossbar with stimulus table, checks and watchdog
module cluster_bus_tb;

  localparam int N_ROWS = 8;
  localparam logic [31:0] RD_KEY [3] = '{32'h0000_a5a5, 32'h5a5a_0000, 32'hffff_0000};

  typedef struct {
    string       name;
    logic [5:0]  cid;
    int          ini;
    logic [31:0] addr;
    logic [3:0]  id;
    int          tgt;
    logic [5:0]  exp_id;
  } row_t;

  // expected target follows base = 0x5000_0000 + (cid << 22)
  row_t rows [N_ROWS] = '{
    '{"tcdm_c0",    6'd0, 0, 32'h5000_0100, 4'h3, 0, 6'h03},
    '{"periph_c0",  6'd0, 1, 32'h5020_0040, 4'h5, 1, 6'h15},
    '{"ext_c0",     6'd0, 2, 32'h5040_0000, 4'h9, 2, 6'h29},
    '{"tcdm_c3",    6'd3, 3, 32'h50c0_1234, 4'ha, 0, 6'h3a},
    '{"periph_c3",  6'd3, 0, 32'h50e0_0010, 4'h1, 1, 6'h01},
    '{"above_c3",   6'd3, 1, 32'h5100_0000, 4'h7, 2, 6'h17},
    '{"below_c3",   6'd3, 2, 32'h4000_0000, 4'hc, 2, 6'h2c},
    '{"far_top_c0", 6'd0, 3, 32'h9000_0000, 4'hf, 2, 6'h3f}
  };

  logic                           clk;
  logic                           rst_n;
  logic [5:0]                     cluster_id;
  cluster_bus_chan_pkg::init_req_t init_req [4];
  logic [3:0]                     init_req_ready;
  cluster_bus_chan_pkg::init_rsp_t init_rsp [4];
  logic [3:0]                     init_rsp_ready;
  cluster_bus_chan_pkg::tgt_req_t  tgt_req [3];
  logic [2:0]                     tgt_req_ready;
  cluster_bus_chan_pkg::tgt_rsp_t  tgt_rsp [3];
  logic [2:0]                     tgt_rsp_ready;
  logic [2:0]                     stall;
  int  pass_cnt;
  int  fail_cnt;
  bit  test_ok;

  cluster_bus_xbar u_dut (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .cluster_id_i     (cluster_id),
    .init_req_i       (init_req),
    .init_req_ready_o (init_req_ready),
    .init_rsp_o       (init_rsp),
    .init_rsp_ready_i (init_rsp_ready),
    .tgt_req_o        (tgt_req),
    .tgt_req_ready_i  (tgt_req_ready),
    .tgt_rsp_i        (tgt_rsp),
    .tgt_rsp_ready_o  (tgt_rsp_ready)
  );

  for (genvar t = 0; t < 3; t++) begin : g_model
    cluster_bus_target_model #(.RD_KEY(RD_KEY[t])) u_model (
      .clk_i       (clk),
      .rst_n_i     (rst_n),
      .stall_i     (stall[t]),
      .req_i       (tgt_req[t]),
      .req_ready_o (tgt_req_ready[t]),
      .rsp_o       (tgt_rsp[t]),
      .rsp_ready_i (tgt_rsp_ready[t])
    );
  end

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // limit scales with the number of tests
  initial begin
    #((N_ROWS + 3) * 50 * 20);
    $display("watchdog expired before all tests finished");
    $display("Test failed");
    $finish;
  end

  task automatic check_req(input string name, input cluster_bus_chan_pkg::tgt_req_t exp,
                           input cluster_bus_chan_pkg::tgt_req_t act);
    if (act !== exp) begin
      $display("error %s request expected %h actual %h", name, exp, act);
      test_ok = 0;
    end
  endtask

  task automatic check_rsp(input string name, input cluster_bus_chan_pkg::init_rsp_t exp,
                           input cluster_bus_chan_pkg::init_rsp_t act);
    if (act !== exp) begin
      $display("error %s response expected %h actual %h", name, exp, act);
      test_ok = 0;
    end
  endtask

  task automatic close_test(input string name);
    if (test_ok) begin
      pass_cnt++;
      $display("ok     %s", name);
    end else begin
      fail_cnt++;
      $display("FAILED %s", name);
    end
  endtask

  function automatic cluster_bus_chan_pkg::tgt_req_t make_req(logic [31:0] addr,
                                                              logic [5:0] id);
    make_req = '{valid: 1'b1, we: 1'b0, addr: addr, wdata: ~addr, id: id};
  endfunction

  task automatic drive_req(input int ini, input logic [31:0] addr, input logic [3:0] id);
    init_req[ini] = '{valid: 1'b1, we: 1'b0, addr: addr, wdata: ~addr, id: id};
  endtask

  // wait for the beat at the target, then for the response at the initiator
  task automatic complete_req(input string name, input int ini, input logic [31:0] addr,
                              input logic [3:0] id, input int tgt, input logic [5:0] exp_id);
    cluster_bus_chan_pkg::init_rsp_t exp_rsp;
    int cnt;
    bit got;
    exp_rsp = '{valid: 1'b1, rdata: addr ^ RD_KEY[tgt], id: id};
    cnt = 0;
    got = 0;
    while (!got && cnt < 20) begin
      @(posedge clk);
      if (tgt_req[tgt].valid && tgt_req_ready[tgt]) begin
        got = 1;
        check_req(name, make_req(addr, exp_id), tgt_req[tgt]);
        if (!init_req_ready[ini]) begin
          $display("%s initiator ready stayed low on an accepted beat", name);
          test_ok = 0;
        end
      end
      cnt++;
    end
    @(negedge clk);
    init_req[ini].valid = 1'b0;
    if (!got) begin
      $display("%s request never reached target %0d", name, tgt);
      test_ok = 0;
    end else begin
      cnt = 0;
      got = 0;
      while (!got && cnt < 20) begin
        @(posedge clk);
        if (init_rsp[ini].valid) begin
          got = 1;
          check_rsp(name, exp_rsp, init_rsp[ini]);
          // the delivered beat is also acknowledged at its target
          if (!tgt_rsp_ready[tgt]) begin
            $display("%s target %0d response ready low on a delivered beat", name, tgt);
            test_ok = 0;
          end
        end
        cnt++;
      end
      if (!got) begin
        $display("%s response never reached initiator %0d", name, ini);
        test_ok = 0;
      end
    end
  endtask

  task automatic check_idle(input string name);
    for (int k = 0; k < 4; k++) begin
      if (k < 3 && tgt_req[k].valid !== 1'b0) begin
        $display("%s target %0d request valid is not low", name, k);
        test_ok = 0;
      end
      if (init_rsp[k].valid !== 1'b0) begin
        $display("%s initiator %0d response valid is not low", name, k);
        test_ok = 0;
      end
    end
  endtask

  initial begin
    cluster_bus_chan_pkg::tgt_req_t exp_beats [3];
    logic [3:0] acc;
    int nbeat;
    int cnt;
    bit resent;
    rst_n          = 1'b0;
    cluster_id     = 6'd0;
    init_rsp_ready = 4'hf;
    stall          = 3'b000;
    pass_cnt       = 0;
    fail_cnt       = 0;
    for (int i = 0; i < 4; i++) begin
      init_req[i] = '0;
    end

    test_ok = 1;
    repeat (2) @(posedge clk);
    check_idle("reset");
    @(negedge clk);
    rst_n = 1'b1;
    @(posedge clk);
    check_idle("reset");
    close_test("reset");

    // pointer is 0 after reset, so initiator 1 wins first
    // and its second request waits behind initiator 3
    test_ok = 1;
    exp_beats[0] = make_req(32'h5000_0100, 6'h11);
    exp_beats[1] = make_req(32'h5000_0300, 6'h33);
    exp_beats[2] = make_req(32'h5000_0140, 6'h12);
    resent = 0;
    @(negedge clk);
    drive_req(3, 32'h5000_0300, 4'h3);
    drive_req(1, 32'h5000_0100, 4'h1);
    nbeat = 0;
    cnt = 0;
    while (nbeat < 3 && cnt < 40) begin
      @(posedge clk);
      if (tgt_req[0].valid && tgt_req_ready[0]) begin
        check_req("contention", exp_beats[nbeat], tgt_req[0]);
        nbeat++;
      end
      acc = init_req_ready;
      @(negedge clk);
      for (int i = 0; i < 4; i++) begin
        if (acc[i] && i == 1 && !resent) begin
          drive_req(1, 32'h5000_0140, 4'h2);
          resent = 1;
        end else if (acc[i]) begin
          init_req[i].valid = 1'b0;
        end
      end
      cnt++;
    end
    if (nbeat < 3) begin
      $display("contention only %0d of 3 requests were served", nbeat);
      test_ok = 0;
    end
    repeat (3) @(posedge clk);
    close_test("contention");

    test_ok = 1;
    @(negedge clk);
    stall[1] = 1'b1;
    drive_req(2, 32'h5020_0080, 4'h6);
    @(negedge clk);
    // initiator 1 comes before 2 in round-robin order and must wait behind the lock
    drive_req(1, 32'h5020_00c0, 4'h4);
    repeat (4) begin
      @(posedge clk);
      check_req("backpressure", make_req(32'h5020_0080, 6'h26), tgt_req[1]);
      if (init_req_ready[1] || init_req_ready[2]) begin
        $display("backpressure initiator ready rose while target was stalled");
        test_ok = 0;
      end
    end
    @(negedge clk);
    stall[1] = 1'b0;
    complete_req("backpressure", 2, 32'h5020_0080, 4'h6, 1, 6'h26);
    complete_req("backpressure", 1, 32'h5020_00c0, 4'h4, 1, 6'h14);
    close_test("backpressure");

    for (int r = 0; r < N_ROWS; r++) begin
      test_ok = 1;
      @(negedge clk);
      cluster_id = rows[r].cid;
      drive_req(rows[r].ini, rows[r].addr, rows[r].id);
      complete_req(rows[r].name, rows[r].ini, rows[r].addr, rows[r].id, rows[r].tgt,
                   rows[r].exp_id);
      close_test(rows[r].name);
    end

    $display("passed %0d failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
